/* logic/edge_fifo.sv */
`timescale 1ns/1ps

module edge_fifo #(
  parameter int FIFO_ADDR_W = 4
) (
  input  logic                                               CLK,
  input  logic                                               RST,
  input  logic                                               enq,
  input  logic [graph_pkg::NODE_ADDR_W+relax_pkg::EDGE_COST_W-1:0] wdata,
  input  logic                                               deq,
  output logic [graph_pkg::NODE_ADDR_W+relax_pkg::EDGE_COST_W-1:0] q,
  output logic                                               empty,
  output logic                                               full,
  output logic                                               alm_full
);

  import graph_pkg::*;
  import relax_pkg::*;

  localparam int DATA_W = NODE_ADDR_W + EDGE_COST_W;
  localparam int DEPTH  = 2 ** FIFO_ADDR_W;

  logic [DATA_W-1:0]      mem [DEPTH];
  logic [FIFO_ADDR_W-1:0] head;
  logic [FIFO_ADDR_W-1:0] tail;
  logic [FIFO_ADDR_W-1:0] head_nxt;
  logic [FIFO_ADDR_W-1:0] tail_nxt;
  logic [FIFO_ADDR_W-1:0] tail_p1;
  logic [FIFO_ADDR_W-1:0] tail_p2;
  logic                   do_enq;
  logic                   do_deq;

  assign do_enq = enq && !full;
  assign do_deq = deq && !empty;

  // ------------------------------------------------------------------------
  // pointers of the next cycle
  // ------------------------------------------------------------------------
  always_comb begin
    head_nxt = do_deq ? head + 1'b1 : head;
    tail_nxt = do_enq ? tail + 1'b1 : tail;
    tail_p1  = tail_nxt + 1'b1;
    tail_p2  = tail_nxt + 2'd2;
  end

  // one slot is kept free so that full and empty differ
  always_ff @(posedge CLK) begin
    if (RST) begin
      head     <= '0;
      tail     <= '0;
      empty    <= 1'b1;
      full     <= 1'b0;
      alm_full <= 1'b0;
    end else begin
      head     <= head_nxt;
      tail     <= tail_nxt;
      empty    <= (head_nxt == tail_nxt);
      full     <= (head_nxt == tail_p1);
      alm_full <= (head_nxt == tail_p1) || (head_nxt == tail_p2);
    end
  end

  // ------------------------------------------------------------------------
  // storage
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (do_enq) begin
      mem[tail] <= wdata;
    end
  end

  assign q = mem[head];  // head entry, no read latency

  a_no_enq_full: assert property (
    @(posedge CLK) disable iff (RST)
    !(enq && full)
  ) else $error("edge FIFO written while full");

  a_no_deq_empty: assert property (
    @(posedge CLK) disable iff (RST)
    !(deq && empty)
  ) else $error("edge FIFO popped while empty");

endmodule

/* logic/edge_intake.sv */
`timescale 1ns/1ps

module edge_intake (
  input  logic                                               CLK,
  input  logic                                               RST,
  input  logic                                               start,
  input  logic                                               busy,
  input  logic                                               edge_valid,
  input  logic [graph_pkg::NODE_ADDR_W-1:0]                  edge_dst,
  input  logic [relax_pkg::EDGE_COST_W-1:0]                  edge_cost,
  input  logic                                               edge_last,
  input  logic                                               fifo_alm_full,
  output logic                                               edge_ready,
  output logic                                               fifo_enq,
  output logic [graph_pkg::NODE_ADDR_W+relax_pkg::EDGE_COST_W-1:0] fifo_wdata,
  output logic                                               intake_done
);

  // ------------------------------------------------------------------------
  // stream gating
  // ------------------------------------------------------------------------
  // stop taking edges once the last one is in, or when the FIFO backs up
  assign edge_ready = busy && !intake_done && !fifo_alm_full;
  assign fifo_enq   = edge_valid && edge_ready;

  // destination on top, weight below
  assign fifo_wdata = {edge_dst, edge_cost};

  // last-edge flag for the current expansion
  always_ff @(posedge CLK) begin
    if (RST) begin
      intake_done <= 1'b0;
    end else if (start && !busy) begin
      intake_done <= 1'b0;  // new expansion
    end else if (fifo_enq && edge_last) begin
      intake_done <= 1'b1;
    end
  end

  // an edge is only taken inside an expansion, and that expansion cannot
  // end in the very next cycle since the edge still sits in the FIFO
  a_enq_in_expansion: assert property (
    @(posedge CLK) disable iff (RST)
    fifo_enq |-> busy ##1 busy
  ) else $error("edge taken outside of an expansion");

endmodule

/* logic/graph_pkg.sv */
package graph_pkg;

  // ------------------------------------------------------------------------
  // stored graph geometry
  // ------------------------------------------------------------------------
  localparam int NODE_ADDR_W = 8;   // 256 nodes
  localparam int COST_W      = 16;
  localparam int NODE_WORD_W = 1 + NODE_ADDR_W + COST_W;

  // relax side view of a node word
  typedef struct packed {
    logic                   visited;  // top bit
    logic [NODE_ADDR_W-1:0] parent;
    logic [COST_W-1:0]      cost;
  } node_rec_t;

  // host loads and reads back the raw word, the relax unit decodes the record
  typedef union packed {
    logic [NODE_WORD_W-1:0] raw;
    node_rec_t              rec;
  } node_word_u;

endpackage

/* logic/node_table.sv */
`timescale 1ns/1ps

module node_table (
  input  logic                              CLK,
  input  logic                              host_wr_en,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] host_wr_addr,
  input  logic [graph_pkg::NODE_WORD_W-1:0] host_wr_data,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] host_rd_addr,
  input  logic                              visit_en,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] visit_addr,
  input  logic                              upd_en,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] upd_addr,
  input  graph_pkg::node_word_u             upd_word,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] rec_addr,
  output logic [graph_pkg::NODE_WORD_W-1:0] host_rd_data,
  output graph_pkg::node_word_u             rec_word
);

  import graph_pkg::*;

  localparam int NUM_NODES = 2 ** NODE_ADDR_W;

  node_word_u mem [NUM_NODES];
  node_word_u visit_word;
  logic [2:0] wr_sel;

  // read-modify-write, only the visited bit changes
  always_comb begin
    visit_word             = mem[visit_addr];
    visit_word.rec.visited = 1'b1;
  end

  // ------------------------------------------------------------------------
  // write port, visit first, then update, then host
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (visit_en) begin
      mem[visit_addr] <= visit_word;
    end else if (upd_en) begin
      mem[upd_addr] <= upd_word;
    end else if (host_wr_en) begin
      mem[host_wr_addr].raw <= host_wr_data;
    end
  end

  // host read-back, one cycle
  always_ff @(posedge CLK) begin
    host_rd_data <= mem[host_rd_addr].raw;
  end

  // relax side sees a write of cycle t in cycle t+1
  assign rec_word = mem[rec_addr];

  assign wr_sel = {visit_en, upd_en, host_wr_en};

  // host writes only while idle, and visit and update never collide
  a_one_writer: assert property (
    @(posedge CLK)
    $isunknown(wr_sel) || $onehot0(wr_sel)
  ) else $error("node table written by more than one port");

endmodule

/* logic/relax_pkg.sv */
package relax_pkg;

  // ------------------------------------------------------------------------
  // cost arithmetic
  // ------------------------------------------------------------------------
  localparam int EDGE_COST_W = 8;

  // all ones means not reached yet
  localparam logic [graph_pkg::COST_W-1:0] INF_COST = '1;

  // current cost plus edge weight, clamped at INF_COST
  function automatic logic [graph_pkg::COST_W-1:0] cost_sum(
    input logic [graph_pkg::COST_W-1:0] cur_cost,
    input logic [EDGE_COST_W-1:0]       edge_cost
  );
    logic [graph_pkg::COST_W:0] sum;  // one carry bit
    sum = {1'b0, cur_cost} + edge_cost;
    if (sum[graph_pkg::COST_W]) begin
      return INF_COST;
    end
    return sum[graph_pkg::COST_W-1:0];
  endfunction

endpackage

/* logic/relax_top.sv */
`timescale 1ns/1ps

module relax_top #(
  parameter int FIFO_ADDR_W = 4
) (
  input  logic                              CLK,
  input  logic                              RST,
  input  logic                              node_wr_en,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] node_wr_addr,
  input  logic [graph_pkg::NODE_WORD_W-1:0] node_wr_data,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] node_rd_addr,
  output logic [graph_pkg::NODE_WORD_W-1:0] node_rd_data,
  input  logic                              start,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] start_node,
  input  logic [graph_pkg::COST_W-1:0]      start_cost,
  input  logic                              edge_valid,
  input  logic [graph_pkg::NODE_ADDR_W-1:0] edge_dst,
  input  logic [relax_pkg::EDGE_COST_W-1:0] edge_cost,
  input  logic                              edge_last,
  output logic                              edge_ready,
  output logic                              push_valid,
  output logic [graph_pkg::NODE_ADDR_W-1:0] push_node,
  output logic [graph_pkg::COST_W-1:0]      push_cost,
  input  logic                              push_ready,
  output logic                              busy,
  output logic                              done
);

  import graph_pkg::*;
  import relax_pkg::*;

  localparam int FIFO_W = NODE_ADDR_W + EDGE_COST_W;

  logic                   fifo_enq;
  logic                   fifo_deq;
  logic                   fifo_empty;
  logic                   fifo_alm_full;
  logic [FIFO_W-1:0]      fifo_wdata;
  logic [FIFO_W-1:0]      fifo_q;
  logic                   intake_done;
  logic                   visit_en;
  logic [NODE_ADDR_W-1:0] visit_addr;
  logic                   upd_en;
  logic [NODE_ADDR_W-1:0] upd_addr;
  node_word_u             upd_word;
  logic [NODE_ADDR_W-1:0] rec_addr;
  node_word_u             rec_word;

  // neighbor record follows the FIFO head
  assign rec_addr = fifo_q[FIFO_W-1 -: NODE_ADDR_W];

  // ------------------------------------------------------------------------
  // producer, buffer, consumer and node memory
  // ------------------------------------------------------------------------
  edge_intake u_intake (
    .CLK(CLK), .RST(RST), .start(start), .busy(busy),
    .edge_valid(edge_valid), .edge_dst(edge_dst), .edge_cost(edge_cost),
    .edge_last(edge_last), .fifo_alm_full(fifo_alm_full), .edge_ready(edge_ready),
    .fifo_enq(fifo_enq), .fifo_wdata(fifo_wdata), .intake_done(intake_done)
  );

  edge_fifo #(.FIFO_ADDR_W(FIFO_ADDR_W)) u_fifo (
    .CLK(CLK), .RST(RST), .enq(fifo_enq), .wdata(fifo_wdata), .deq(fifo_deq),
    .q(fifo_q), .empty(fifo_empty), .full(), .alm_full(fifo_alm_full)
  );

  node_table u_nodes (
    .CLK(CLK), .host_wr_en(node_wr_en), .host_wr_addr(node_wr_addr),
    .host_wr_data(node_wr_data), .host_rd_addr(node_rd_addr),
    .visit_en(visit_en), .visit_addr(visit_addr), .upd_en(upd_en),
    .upd_addr(upd_addr), .upd_word(upd_word), .rec_addr(rec_addr),
    .host_rd_data(node_rd_data), .rec_word(rec_word)
  );

  relax_unit u_relax (
    .CLK(CLK), .RST(RST), .start(start), .start_node(start_node),
    .start_cost(start_cost), .fifo_q(fifo_q), .fifo_empty(fifo_empty),
    .intake_done(intake_done), .rec_word(rec_word), .push_ready(push_ready),
    .busy(busy), .done(done), .fifo_deq(fifo_deq), .visit_en(visit_en),
    .visit_addr(visit_addr), .upd_en(upd_en), .upd_addr(upd_addr),
    .upd_word(upd_word), .push_valid(push_valid), .push_node(push_node),
    .push_cost(push_cost)
  );

endmodule

/* logic/relax_unit.sv */
`timescale 1ns/1ps

module relax_unit (
  input  logic                                               CLK,
  input  logic                                               RST,
  input  logic                                               start,
  input  logic [graph_pkg::NODE_ADDR_W-1:0]                  start_node,
  input  logic [graph_pkg::COST_W-1:0]                       start_cost,
  input  logic [graph_pkg::NODE_ADDR_W+relax_pkg::EDGE_COST_W-1:0] fifo_q,
  input  logic                                               fifo_empty,
  input  logic                                               intake_done,
  input  graph_pkg::node_word_u                              rec_word,
  input  logic                                               push_ready,
  output logic                                               busy,
  output logic                                               done,
  output logic                                               fifo_deq,
  output logic                                               visit_en,
  output logic [graph_pkg::NODE_ADDR_W-1:0]                  visit_addr,
  output logic                                               upd_en,
  output logic [graph_pkg::NODE_ADDR_W-1:0]                  upd_addr,
  output graph_pkg::node_word_u                              upd_word,
  output logic                                               push_valid,
  output logic [graph_pkg::NODE_ADDR_W-1:0]                  push_node,
  output logic [graph_pkg::COST_W-1:0]                       push_cost
);

  import graph_pkg::*;
  import relax_pkg::*;

  logic [NODE_ADDR_W-1:0] cur_node;
  logic [COST_W-1:0]      cur_cost;
  logic [NODE_ADDR_W-1:0] head_dst;
  logic [EDGE_COST_W-1:0] head_cost;
  logic [COST_W-1:0]      new_cost;
  logic                   launch;
  logic                   head_live;
  logic                   relax;
  logic                   fin;

  assign launch = start && !busy;  // start is dropped while busy

  // ------------------------------------------------------------------------
  // expansion control
  // ------------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (RST) begin
      busy     <= 1'b0;
      done     <= 1'b0;
      visit_en <= 1'b0;
    end else begin
      done     <= fin;
      visit_en <= launch;  // first busy cycle marks the node
      if (launch) begin
        busy <= 1'b1;
      end else if (fin) begin
        busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge CLK) begin
    if (launch) begin
      cur_node <= start_node;
      cur_cost <= start_cost;
    end
  end

  assign visit_addr = cur_node;

  // all edges in, FIFO drained, nothing waiting on the frontier
  assign fin = busy && intake_done && fifo_empty && !push_valid;

  // ------------------------------------------------------------------------
  // relaxation of the FIFO head
  // ------------------------------------------------------------------------
  assign head_dst  = fifo_q[NODE_ADDR_W+EDGE_COST_W-1 -: NODE_ADDR_W];
  assign head_cost = fifo_q[EDGE_COST_W-1:0];
  assign new_cost  = cost_sum(cur_cost, head_cost);
  assign head_live = busy && !fifo_empty;

  // a saturated sum never beats a stored cost
  assign relax = !rec_word.rec.visited && (rec_word.rec.cost > new_cost);

  assign push_valid = head_live && relax;
  assign push_node  = head_dst;
  assign push_cost  = new_cost;

  // non-improving edges leave at once, improving ones wait for the push
  assign fifo_deq = head_live && (!relax || push_ready);

  // node write lands in the pop cycle
  assign upd_en   = push_valid && push_ready;
  assign upd_addr = head_dst;

  always_comb begin
    upd_word.rec.visited = 1'b0;
    upd_word.rec.parent  = cur_node;
    upd_word.rec.cost    = new_cost;
  end

  // head entry and its record must not move under a stalled push
  a_push_hold: assert property (
    @(posedge CLK) disable iff (RST)
    push_valid && !push_ready |=>
      push_valid && $stable(push_node) && $stable(push_cost)
  ) else $error("frontier push changed while stalled");

endmodule

/* src.f */
logic/graph_pkg.sv
logic/relax_pkg.sv
logic/edge_intake.sv
logic/edge_fifo.sv
logic/node_table.sv
logic/relax_unit.sv
logic/relax_top.sv
verification/relax_tb.sv

/* verification/relax_tb.sv */
`timescale 1ns/1ps

module relax_tb;

  import graph_pkg::*;
  import relax_pkg::*;

  localparam int NUM_NODES  = 2 ** NODE_ADDR_W;
  localparam int LOW_NODES  = 16;   // edges only reach these
  localparam int NUM_EXP    = 40;
  localparam int EXP_CYCLES = 300;
  localparam int LOAD_CYCLES = 8 + (NUM_NODES + 1) + 2 * NUM_NODES
                             + (NUM_EXP / 4 + 1) * (LOW_NODES + 1)
                             + NUM_EXP * 2 * LOW_NODES + 2 * NUM_NODES;
  localparam int TIMEOUT_CYCLES = NUM_EXP * EXP_CYCLES + LOAD_CYCLES;

  logic                   CLK;
  logic                   RST;
  logic                   node_wr_en;
  logic [NODE_ADDR_W-1:0] node_wr_addr;
  logic [NODE_WORD_W-1:0] node_wr_data;
  logic [NODE_ADDR_W-1:0] node_rd_addr;
  logic [NODE_WORD_W-1:0] node_rd_data;
  logic                   start;
  logic [NODE_ADDR_W-1:0] start_node;
  logic [COST_W-1:0]      start_cost;
  logic                   edge_valid;
  logic [NODE_ADDR_W-1:0] edge_dst;
  logic [EDGE_COST_W-1:0] edge_cost;
  logic                   edge_last;
  logic                   edge_ready;
  logic                   push_valid;
  logic [NODE_ADDR_W-1:0] push_node;
  logic [COST_W-1:0]      push_cost;
  logic                   push_ready;
  logic                   busy;
  logic                   done;

  node_word_u  model [NUM_NODES];  // expected node table
  logic [31:0] lfsr = 32'h442c2365;
  int          cycle_cnt = 0;
  int          checks = 0;
  int          mismatch_errs = 0;
  int          other_errs = 0;

  // shallow FIFO so that stalled pushes reach almost full
  relax_top #(.FIFO_ADDR_W(2)) DUT (
    .CLK(CLK), .RST(RST),
    .node_wr_en(node_wr_en), .node_wr_addr(node_wr_addr), .node_wr_data(node_wr_data),
    .node_rd_addr(node_rd_addr), .node_rd_data(node_rd_data),
    .start(start), .start_node(start_node), .start_cost(start_cost),
    .edge_valid(edge_valid), .edge_dst(edge_dst), .edge_cost(edge_cost),
    .edge_last(edge_last), .edge_ready(edge_ready),
    .push_valid(push_valid), .push_node(push_node), .push_cost(push_cost),
    .push_ready(push_ready), .busy(busy), .done(done)
  );

  initial CLK = 1'b0;
  always #20 CLK = ~CLK;

  // ------------------------------------------------------------------------
  // random source and reference arithmetic
  // ------------------------------------------------------------------------
  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_shift(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    int          i;
    val = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_shift(lfsr);
      val  = {val[30:0], lfsr[0]};  // one step per bit
    end
    return val;
  endfunction

  function automatic logic [COST_W-1:0] saturating_add(input logic [COST_W-1:0] a,
                                                       input logic [EDGE_COST_W-1:0] b);
    logic [31:0] s;
    s = 32'(a) + 32'(b);
    if (s >= (32'd1 << COST_W)) begin
      return INF_COST;
    end
    return s[COST_W-1:0];
  endfunction

  // mix of unreached, far and near costs
  function automatic node_word_u random_node_word();
    node_word_u w;
    logic [1:0] sel;
    w.rec.visited = (take_bits(2) == 0);
    w.rec.parent  = take_bits(NODE_ADDR_W);
    sel           = take_bits(2);
    if (sel == 0) begin
      w.rec.cost = INF_COST;
    end else if (sel == 1) begin
      w.rec.cost = take_bits(COST_W);
    end else begin
      w.rec.cost = take_bits(9);
    end
    return w;
  endfunction

  task automatic compare_hex(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    checks++;
    assert (got === want) else begin
      $display("mismatch %s: got %0h, expected %0h", name, got, want);
      mismatch_errs++;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%s", what);
      other_errs++;
    end
  endtask

  // ------------------------------------------------------------------------
  // host port
  // ------------------------------------------------------------------------
  task automatic load_nodes(input int first, input int count);
    node_word_u w;
    int         a;
    for (a = first; a < first + count; a++) begin
      @(posedge CLK);
      #1;
      w            = random_node_word();
      node_wr_en   = 1'b1;
      node_wr_addr = a;
      node_wr_data = w.raw;
      model[a]     = w;
    end
    @(posedge CLK);
    #1;
    node_wr_en = 1'b0;
  endtask

  task automatic check_node(input int addr);
    @(posedge CLK);
    #1;
    node_rd_addr = addr;
    @(posedge CLK);
    @(negedge CLK);  // registered read data settled
    compare_hex($sformatf("node_rd_data[%0d]", addr), node_rd_data, model[addr].raw);
  endtask

  // ------------------------------------------------------------------------
  // one expansion with its edge list and expected pushes
  // ------------------------------------------------------------------------
  task automatic expand_node(input int idx);
    logic [NODE_ADDR_W-1:0]        node;
    logic [COST_W-1:0]             cost;
    logic [COST_W-1:0]             sum;
    logic [NODE_ADDR_W-1:0]        dsts [$];
    logic [EDGE_COST_W-1:0]        wts [$];
    logic [NODE_ADDR_W+COST_W-1:0] pushes [$];
    logic [NODE_ADDR_W+COST_W-1:0] want;
    logic [NODE_ADDR_W-1:0]        d;
    int n_edges;
    int i;
    int sent;
    int gap;
    int done_cnt;
    int tail_cycles;
    bit edge_taken;
    n_edges = take_bits(4) % 13;
    if (idx == 0) begin
      n_edges = 0;
    end
    node = take_bits(4);
    if (take_bits(2) == 0) begin
      cost = 16'hff80 | take_bits(7);  // near saturation
    end else begin
      cost = take_bits(8);
    end
    if (n_edges == 0) begin
      dsts.push_back(take_bits(4));  // lone last edge of weight zero
      wts.push_back('0);
    end
    for (i = 0; i < n_edges; i++) begin
      dsts.push_back(take_bits(4));
      wts.push_back(take_bits(EDGE_COST_W));
    end
    // reference relaxation in edge order
    model[node].rec.visited = 1'b1;
    for (i = 0; i < dsts.size(); i++) begin
      d   = dsts[i];
      sum = saturating_add(cost, wts[i]);
      if (!model[d].rec.visited && model[d].rec.cost > sum) begin
        model[d].rec.parent = node;
        model[d].rec.cost   = sum;
        pushes.push_back({d, sum});
      end
    end
    @(posedge CLK);
    #1;
    start      = 1'b1;
    start_node = node;
    start_cost = cost;
    edge_valid = 1'b1;  // first edge already offered while idle
    edge_dst   = dsts[0];
    edge_cost  = wts[0];
    edge_last  = (dsts.size() == 1);
    @(negedge CLK);
    expect_true(!edge_ready, "edge_ready high before the expansion started");
    @(posedge CLK);
    #1;
    start       = 1'b0;
    sent        = 0;
    gap         = 0;
    done_cnt    = 0;
    tail_cycles = 0;
    while (tail_cycles < 3) begin
      @(negedge CLK);
      edge_taken = edge_valid && edge_ready;
      expect_true(!edge_taken || busy, "edge accepted while not busy");
      if (push_valid && push_ready) begin
        if (pushes.size() == 0) begin
          expect_true(1'b0, $sformatf("unexpected push of node %0h", push_node));
        end else begin
          want = pushes.pop_front();
          compare_hex("push_node", push_node, want[COST_W +: NODE_ADDR_W]);
          compare_hex("push_cost", push_cost, want[COST_W-1:0]);
        end
      end
      if (done) begin
        done_cnt++;
        compare_hex("edges sent", sent, dsts.size());
        expect_true(pushes.size() == 0, "expected push missing at done");
        expect_true(DUT.fifo_empty, "edge FIFO not drained at done");
      end
      if (done_cnt > 0) begin
        expect_true(!busy, "busy still high after done");
        tail_cycles++;
      end
      @(posedge CLK);
      #1;
      if (edge_taken) begin
        sent++;
        edge_valid = 1'b0;
        gap        = take_bits(2);
      end
      if (!edge_valid && sent < dsts.size()) begin
        if (gap == 0) begin
          edge_valid = 1'b1;
          edge_dst   = dsts[sent];
          edge_cost  = wts[sent];
          edge_last  = (sent == dsts.size() - 1);
        end else begin
          gap--;
        end
      end
      // every third expansion sees heavy back-pressure
      if (idx % 3 == 2) begin
        push_ready = (take_bits(2) == 0);
      end else begin
        push_ready = (take_bits(2) != 0);
      end
    end
    compare_hex("done pulses", done_cnt, 1);
  endtask

  // ------------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------------
  initial begin
    int e;
    int a;
    RST          = 1'b1;
    node_wr_en   = 1'b0;
    node_wr_addr = '0;
    node_wr_data = '0;
    node_rd_addr = '0;
    start        = 1'b0;
    start_node   = '0;
    start_cost   = '0;
    edge_valid   = 1'b0;
    edge_dst     = '0;
    edge_cost    = '0;
    edge_last    = 1'b0;
    push_ready   = 1'b0;
    repeat (5) @(posedge CLK);
    #1;
    RST = 1'b0;
    @(negedge CLK);
    expect_true(!busy && !done && !push_valid && !edge_ready, "outputs not idle after reset");
    expect_true(DUT.fifo_empty, "edge FIFO not empty after reset");
    load_nodes(0, NUM_NODES);
    for (a = 0; a < NUM_NODES; a++) begin
      check_node(a);
    end
    for (e = 0; e < NUM_EXP; e++) begin
      if (e % 4 == 0) begin
        load_nodes(0, LOW_NODES);  // fresh costs, fewer visited
      end
      expand_node(e);
      for (a = 0; a < LOW_NODES; a++) begin
        check_node(a);
      end
    end
    for (a = 0; a < NUM_NODES; a++) begin
      check_node(a);
    end
    $display("%0d checks, %0d mismatches, %0d other errors",
             checks, mismatch_errs, other_errs);
    if (mismatch_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycle_cnt);
      $display("%0d checks, %0d mismatches, %0d other errors",
               checks, mismatch_errs, other_errs + 1);
      $display("Some tests failed");
      $finish;
    end
  end

endmodule
